//--- sources.f
+incdir+include
rtl/vchess_pkg.sv
rtl/apb_eval_regs.sv
rtl/evaluate_killer.sv
rtl/evaluate_material.sv
rtl/eval_result.sv
rtl/eval_top.sv
tests/tb_clock.sv
tests/tb_eval_top.sv

//--- tests/tb_eval_top.sv
`include "vchess_settings.svh"

module tb_eval_top;

   localparam int NUM_MATERIAL_BOARDS = 10;
   localparam int NUM_KILLER_ROUNDS   = 6;
   localparam int LATENCY_LIMIT       = 16;
   localparam int CYCLES_PER_OP       = 40;
   localparam int CLOCK_PERIOD        = 20;
   localparam int PLANNED_OPS         = 12 + NUM_MATERIAL_BOARDS + 8 * NUM_KILLER_ROUNDS + 4;
   localparam int TIMEOUT_TIME        = PLANNED_OPS * CYCLES_PER_OP * CLOCK_PERIOD;

   logic                       clk;
   logic                       reset;
   logic                       psel;
   logic                       penable;
   logic                       pwrite;
   logic [`APB_ADDR_WIDTH-1:0] paddr;
   logic [`APB_DATA_WIDTH-1:0] pwdata;
   logic [`APB_DATA_WIDTH-1:0] prdata;
   logic                       pready;
   logic                       pslverr;
   logic [`BOARD_WIDTH-1:0]    board;
   logic                       board_valid;
   logic                       white_to_move;
   logic                       clear_eval;
   logic [`MAX_DEPTH_LOG2-1:0] killer_ply;
   logic [`BOARD_WIDTH-1:0]    killer_board;
   logic                       killer_update;
   vchess_pkg::eval_t          eval_mg;
   vchess_pkg::eval_t          eval_eg;
   logic                       eval_valid;

   // Reference model state.
   logic [31:0]             lfsr_state;
   vchess_pkg::eval_t       model_bonus0;
   vchess_pkg::eval_t       model_bonus1;
   logic [`BOARD_WIDTH-1:0] model_slot0 [`MAX_DEPTH];
   logic [`BOARD_WIDTH-1:0] model_slot1 [`MAX_DEPTH];
   logic                    model_valid0 [`MAX_DEPTH];
   logic                    model_valid1 [`MAX_DEPTH];
   logic [`BOARD_WIDTH-1:0] stored_boards [$];
   logic [3:0]              stored_plies [$];

   tb_clock clock0 (.clk(clk), .reset(reset));

   eval_top dut0
   (
      .clk           (clk),
      .reset         (reset),
      .psel          (psel),
      .penable       (penable),
      .pwrite        (pwrite),
      .paddr         (paddr),
      .pwdata        (pwdata),
      .prdata        (prdata),
      .pready        (pready),
      .pslverr       (pslverr),
      .board         (board),
      .board_valid   (board_valid),
      .white_to_move (white_to_move),
      .clear_eval    (clear_eval),
      .killer_ply    (killer_ply),
      .killer_board  (killer_board),
      .killer_update (killer_update),
      .eval_mg       (eval_mg),
      .eval_eg       (eval_eg),
      .eval_valid    (eval_valid)
   );

   task automatic fail_run(input string reason);
      $display("%s", reason);
      $display("STATUS: FAIL");
      $fatal(1, "simulation stopped");
   endtask

   task automatic check_value(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
      if (actual !== expected)
         fail_run($sformatf("error at time %0t: %s expected 0x%h actual 0x%h",
                            $time, name, expected, actual));
   endtask

   function automatic logic [31:0] lfsr_next(input logic [31:0] state);
      logic [31:0] next;
      next = state >> 1;
      if (state[0])
         next = next ^ 32'hD000_0001; // Taps 32, 31, 29, 1.
      return next;
   endfunction

   function automatic logic [31:0] random_bits(input int count);
      logic [31:0] value;
      int          i;
      value = '0;
      for (i = 0; i < count; i++)
      begin
         lfsr_state = lfsr_next(lfsr_state);
         value      = {value[30:0], lfsr_state[0]};
      end
      return value;
   endfunction

   function automatic logic [`BOARD_WIDTH-1:0] random_board();
      logic [`BOARD_WIDTH-1:0] b;
      logic [2:0]              kind;
      logic                    black;
      int                      sq;
      for (sq = 0; sq < 64; sq++)
      begin
         kind  = random_bits(3) % 7; // Empty through king.
         black = random_bits(1);
         if (kind == 3'd0)
            black = 1'b0;
         b[4 * sq +: 4] = {black, kind};
      end
      return b;
   endfunction

   function automatic vchess_pkg::eval_t material_score(input logic [`BOARD_WIDTH-1:0] b,
                                                        input logic endgame);
      int sum;
      int value;
      int sq;
      sum = 0;
      for (sq = 0; sq < 64; sq++)
      begin
         case (b[4 * sq +: 3])
            3'd1:    value = endgame ? `VAL_EG_PAWN : `VAL_MG_PAWN;
            3'd2:    value = endgame ? `VAL_EG_KNIGHT : `VAL_MG_KNIGHT;
            3'd3:    value = endgame ? `VAL_EG_BISHOP : `VAL_MG_BISHOP;
            3'd4:    value = endgame ? `VAL_EG_ROOK : `VAL_MG_ROOK;
            3'd5:    value = endgame ? `VAL_EG_QUEEN : `VAL_MG_QUEEN;
            default: value = 0; // King or empty.
         endcase
         sum = b[4 * sq + 3] ? sum - value : sum + value;
      end
      return vchess_pkg::eval_t'(sum); // Wraps like the hardware.
   endfunction

   function automatic vchess_pkg::eval_t killer_bonus_for(input logic [`BOARD_WIDTH-1:0] b,
                                                          input logic [3:0] ply,
                                                          input logic wtm);
      vchess_pkg::eval_t bonus;
      if (model_valid0[ply] && b == model_slot0[ply])
         bonus = model_bonus0;
      else if (model_valid1[ply] && b == model_slot1[ply])
         bonus = model_bonus1;
      else
         bonus = '0;
      if (wtm)
         bonus = -bonus;
      return bonus;
   endfunction

   task automatic apb_access(input logic write, input logic [7:0] addr,
                             input logic [31:0] wdata, input logic expect_err,
                             output logic [31:0] rdata);
      @(posedge clk);
      psel    <= 1'b1;
      penable <= 1'b0;
      pwrite  <= write;
      paddr   <= addr;
      pwdata  <= wdata;
      @(posedge clk);
      penable <= 1'b1;
      @(negedge clk);
      rdata = prdata;
      check_value("pready", 32'd1, pready);
      check_value("pslverr", expect_err, pslverr);
      @(posedge clk);
      psel    <= 1'b0;
      penable <= 1'b0;
      pwrite  <= 1'b0;
   endtask

   task automatic apb_write(input logic [7:0] addr, input logic [31:0] data,
                            input logic expect_err);
      logic [31:0] unused;
      int          i;
      apb_access(1'b1, addr, data, expect_err, unused);
      if (addr == `ADDR_BONUS0)
         model_bonus0 = data[15:0];
      else if (addr == `ADDR_BONUS1)
         model_bonus1 = data[15:0];
      else if (addr == `ADDR_CONTROL && data[0])
      begin
         for (i = 0; i < `MAX_DEPTH; i++)
         begin
            model_valid0[i] = 1'b0;
            model_valid1[i] = 1'b0;
         end
      end
   endtask

   task automatic apb_read_check(input string name, input logic [7:0] addr,
                                 input logic [31:0] expected, input logic expect_err);
      logic [31:0] data;
      apb_access(1'b0, addr, 32'd0, expect_err, data);
      check_value(name, expected, data);
   endtask

   task automatic store_killer(input logic [3:0] ply, input logic [`BOARD_WIDTH-1:0] b);
      @(posedge clk);
      killer_ply   <= ply;
      killer_board <= b;
      @(posedge clk);
      killer_update <= 1'b1; // Ply registered on this edge.
      @(posedge clk);
      killer_update <= 1'b0;
      model_slot1[ply]  = model_slot0[ply];
      model_valid1[ply] = model_valid0[ply];
      model_slot0[ply]  = b;
      model_valid0[ply] = 1'b1;
      stored_boards.push_back(b);
      stored_plies.push_back(ply);
   endtask

   task automatic run_eval(input logic [`BOARD_WIDTH-1:0] b, input logic [3:0] ply,
                           input logic wtm);
      vchess_pkg::eval_t bonus;
      vchess_pkg::eval_t exp_mg;
      vchess_pkg::eval_t exp_eg;
      int                cycles;
      int                hold;
      bonus  = killer_bonus_for(b, ply, wtm);
      exp_mg = material_score(b, 1'b0) + bonus;
      exp_eg = material_score(b, 1'b1) + bonus;
      @(posedge clk);
      board         <= b;
      killer_ply    <= ply;
      white_to_move <= wtm;
      board_valid   <= 1'b1;
      @(posedge clk); // Edge that samples the rise.
      cycles = 0;
      while (cycles < LATENCY_LIMIT && eval_valid !== 1'b1)
      begin
         @(posedge clk);
         cycles++;
         @(negedge clk);
      end
      if (eval_valid !== 1'b1)
         fail_run("eval_valid never rose after a board was presented");
      check_value("eval_valid latency", 32'd5, cycles);
      check_value("eval_mg", exp_mg, eval_mg);
      check_value("eval_eg", exp_eg, eval_eg);
      hold = random_bits(3);
      repeat (hold)
      begin
         @(posedge clk);
         @(negedge clk);
         check_value("eval_valid", 32'd1, eval_valid);
         check_value("eval_mg", exp_mg, eval_mg);
         check_value("eval_eg", exp_eg, eval_eg);
      end
      apb_read_check("prdata STATUS", `ADDR_STATUS, 32'd1, 1'b0);
      @(posedge clk);
      clear_eval  <= 1'b1;
      board_valid <= 1'b0;
      @(posedge clk);
      clear_eval <= 1'b0;
      @(negedge clk);
      check_value("eval_valid", 32'd0, eval_valid);
   endtask

   initial
   begin
      #(TIMEOUT_TIME);
      fail_run("the run timed out before all tests finished");
   end

   initial
   begin
      logic [`BOARD_WIDTH-1:0] first;
      logic [`BOARD_WIDTH-1:0] second;
      logic [3:0]              ply;
      int                      i;
      psel          <= 1'b0;
      penable       <= 1'b0;
      pwrite        <= 1'b0;
      paddr         <= '0;
      pwdata        <= '0;
      board         <= '0;
      board_valid   <= 1'b0;
      white_to_move <= 1'b0;
      clear_eval    <= 1'b0;
      killer_ply    <= '0;
      killer_board  <= '0;
      killer_update <= 1'b0;
      lfsr_state   = 32'd39242;
      model_bonus0 = '0;
      model_bonus1 = '0;
      for (i = 0; i < `MAX_DEPTH; i++)
      begin
         model_valid0[i] = 1'b0;
         model_valid1[i] = 1'b0;
      end
      wait (reset === 1'b0);
      @(negedge clk);
      check_value("eval_valid", 32'd0, eval_valid);
      check_value("pslverr", 32'd0, pslverr);
      apb_read_check("prdata STATUS", `ADDR_STATUS, 32'd0, 1'b0);
      apb_read_check("prdata BONUS0", `ADDR_BONUS0, 32'd0, 1'b0);
      apb_write(`ADDR_BONUS0, random_bits(32), 1'b0);
      apb_write(`ADDR_BONUS1, random_bits(32), 1'b0);
      apb_read_check("prdata BONUS0", `ADDR_BONUS0, {16'h0, model_bonus0}, 1'b0);
      apb_read_check("prdata BONUS1", `ADDR_BONUS1, {16'h0, model_bonus1}, 1'b0);
      apb_write(8'h10, random_bits(32), 1'b1); // Unmapped.
      apb_read_check("prdata unmapped", 8'h02, 32'd0, 1'b1);
      apb_read_check("prdata BONUS0", `ADDR_BONUS0, {16'h0, model_bonus0}, 1'b0);
      apb_read_check("prdata BONUS1", `ADDR_BONUS1, {16'h0, model_bonus1}, 1'b0);
      apb_read_check("prdata CONTROL", `ADDR_CONTROL, 32'd0, 1'b0);

      repeat (NUM_MATERIAL_BOARDS)
         run_eval(random_board(), random_bits(4), random_bits(1));

      for (i = 0; i < NUM_KILLER_ROUNDS; i++)
      begin
         if (i == NUM_KILLER_ROUNDS / 2)
         begin
            apb_write(`ADDR_BONUS0, random_bits(32), 1'b0);
            apb_write(`ADDR_BONUS1, random_bits(32), 1'b0);
         end
         ply   = random_bits(4);
         first = random_board();
         store_killer(ply, first);
         run_eval(first, ply, random_bits(1));
         second = random_board();
         store_killer(ply, second); // Pushes the first board to slot 1.
         run_eval(first, ply, random_bits(1));
         run_eval(second, ply, random_bits(1));
         run_eval(second, ply + 4'd1, random_bits(1));
      end

      // Bit 0 clear leaves the table alone.
      apb_write(`ADDR_CONTROL, 32'h0000_0006, 1'b0);
      run_eval(stored_boards[$], stored_plies[$], random_bits(1));
      apb_write(`ADDR_CONTROL, 32'h0000_0001, 1'b0);
      for (i = 0; i < stored_boards.size(); i++)
         run_eval(stored_boards[i], stored_plies[i], random_bits(1));

      $display("STATUS: PASS");
      $finish;
   end

endmodule

//--- tests/tb_clock.sv
module tb_clock
(
   output logic clk,
   output logic reset
);

   initial
   begin
      clk = 1'b0;
      forever
         #10 clk = ~clk; // Period of 20.
   end

   initial
   begin
      reset = 1'b1;
      repeat (5) @(posedge clk);
      reset <= 1'b0;
   end

endmodule

//--- rtl/eval_top.sv
`include "vchess_settings.svh"

module eval_top
(
   input  logic                       clk,
   input  logic                       reset,
   input  logic                       psel,
   input  logic                       penable,
   input  logic                       pwrite,
   input  logic [`APB_ADDR_WIDTH-1:0] paddr,
   input  logic [`APB_DATA_WIDTH-1:0] pwdata,
   output logic [`APB_DATA_WIDTH-1:0] prdata,
   output logic                       pready,
   output logic                       pslverr,
   input  logic [`BOARD_WIDTH-1:0]    board,
   input  logic                       board_valid,
   input  logic                       white_to_move,
   input  logic                       clear_eval,
   input  logic [`MAX_DEPTH_LOG2-1:0] killer_ply,
   input  logic [`BOARD_WIDTH-1:0]    killer_board,
   input  logic                       killer_update,
   output vchess_pkg::eval_t          eval_mg,
   output vchess_pkg::eval_t          eval_eg,
   output logic                       eval_valid
);

   vchess_pkg::eval_t killer_bonus0;
   vchess_pkg::eval_t killer_bonus1;
   logic              killer_clear;
   vchess_pkg::eval_t killer_mg;
   vchess_pkg::eval_t killer_eg;
   logic              killer_valid;
   vchess_pkg::eval_t mat_mg;
   vchess_pkg::eval_t mat_eg;
   logic              mat_valid;

   apb_eval_regs u_regs
   (
      .clk           (clk),
      .reset         (reset),
      .psel          (psel),
      .penable       (penable),
      .pwrite        (pwrite),
      .paddr         (paddr),
      .pwdata        (pwdata),
      .prdata        (prdata),
      .pready        (pready),
      .pslverr       (pslverr),
      .eval_valid    (eval_valid),
      .killer_bonus0 (killer_bonus0),
      .killer_bonus1 (killer_bonus1),
      .killer_clear  (killer_clear)
   );

   evaluate_killer u_killer
   (
      .clk           (clk),
      .reset         (reset),
      .board_valid   (board_valid),
      .board         (board),
      .clear_eval    (clear_eval),
      .white_to_move (white_to_move),
      .killer_ply    (killer_ply),
      .killer_board  (killer_board),
      .killer_update (killer_update),
      .killer_clear  (killer_clear),
      .killer_bonus0 (killer_bonus0),
      .killer_bonus1 (killer_bonus1),
      .eval_mg       (killer_mg),
      .eval_eg       (killer_eg),
      .eval_valid    (killer_valid)
   );

   evaluate_material u_material
   (
      .clk         (clk),
      .reset       (reset),
      .board_valid (board_valid),
      .board       (board),
      .clear_eval  (clear_eval),
      .mat_mg      (mat_mg),
      .mat_eg      (mat_eg),
      .mat_valid   (mat_valid)
   );

   eval_result u_result
   (
      .clk          (clk),
      .reset        (reset),
      .killer_mg    (killer_mg),
      .killer_eg    (killer_eg),
      .killer_valid (killer_valid),
      .mat_mg       (mat_mg),
      .mat_eg       (mat_eg),
      .mat_valid    (mat_valid),
      .clear_eval   (clear_eval),
      .eval_mg      (eval_mg),
      .eval_eg      (eval_eg),
      .eval_valid   (eval_valid)
   );

endmodule

//--- rtl/eval_result.sv
module eval_result
(
   input  logic              clk,
   input  logic              reset,
   input  vchess_pkg::eval_t killer_mg,
   input  vchess_pkg::eval_t killer_eg,
   input  logic              killer_valid,
   input  vchess_pkg::eval_t mat_mg,
   input  vchess_pkg::eval_t mat_eg,
   input  logic              mat_valid,
   input  logic              clear_eval,
   output vchess_pkg::eval_t eval_mg,
   output vchess_pkg::eval_t eval_eg,
   output logic              eval_valid
);

   logic both_valid;
   logic capture;

   assign both_valid = killer_valid && mat_valid;
   assign capture    = both_valid && !eval_valid && !clear_eval;

   // Sums wrap at the score width.
   always_ff @(posedge clk)
   begin
      if (capture)
      begin
         eval_mg <= killer_mg + mat_mg;
         eval_eg <= killer_eg + mat_eg;
      end
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         eval_valid <= 1'b0;
      end
      else
      begin
         if (clear_eval)
            eval_valid <= 1'b0;
         else if (capture)
            eval_valid <= 1'b1; // Held until the host clears it.
      end
   end

endmodule

//--- rtl/evaluate_material.sv
`include "vchess_settings.svh"

module evaluate_material
(
   input  logic                    clk,
   input  logic                    reset,
   input  logic                    board_valid,
   input  logic [`BOARD_WIDTH-1:0] board,
   input  logic                    clear_eval,
   output vchess_pkg::eval_t       mat_mg,
   output vchess_pkg::eval_t       mat_eg,
   output logic                    mat_valid
);

   logic                 board_valid_r;
   logic                 board_start;
   logic [2:0]           valid_sr;
   vchess_pkg::eval_t    rank_mg_next [8];
   vchess_pkg::eval_t    rank_eg_next [8];
   vchess_pkg::eval_t    rank_mg [8];
   vchess_pkg::eval_t    rank_eg [8];
   vchess_pkg::eval_t    total_mg;
   vchess_pkg::eval_t    total_eg;

   function automatic vchess_pkg::eval_t piece_value(vchess_pkg::square_t sq, logic endgame);
      vchess_pkg::eval_t value;
      case (sq.kind)
         vchess_pkg::PIECE_PAWN:   value = endgame ? `VAL_EG_PAWN : `VAL_MG_PAWN;
         vchess_pkg::PIECE_KNIGHT: value = endgame ? `VAL_EG_KNIGHT : `VAL_MG_KNIGHT;
         vchess_pkg::PIECE_BISHOP: value = endgame ? `VAL_EG_BISHOP : `VAL_MG_BISHOP;
         vchess_pkg::PIECE_ROOK:   value = endgame ? `VAL_EG_ROOK : `VAL_MG_ROOK;
         vchess_pkg::PIECE_QUEEN:  value = endgame ? `VAL_EG_QUEEN : `VAL_MG_QUEEN;
         default:                  value = '0; // Empty square and king.
      endcase
      return sq.black ? -value : value;
   endfunction

   assign board_start = board_valid && !board_valid_r;

   // Per-rank sums for stage one and the total for stage two.
   always_comb
   begin
      for (int r = 0; r < 8; r++)
      begin
         rank_mg_next[r] = '0;
         rank_eg_next[r] = '0;
         for (int f = 0; f < 8; f++)
         begin
            rank_mg_next[r] += piece_value(board[4 * (8 * r + f) +: 4], 1'b0);
            rank_eg_next[r] += piece_value(board[4 * (8 * r + f) +: 4], 1'b1);
         end
      end
      total_mg = '0;
      total_eg = '0;
      for (int r = 0; r < 8; r++)
      begin
         total_mg += rank_mg[r];
         total_eg += rank_eg[r];
      end
   end

   always_ff @(posedge clk)
   begin
      if (board_start)
      begin
         rank_mg <= rank_mg_next;
         rank_eg <= rank_eg_next;
      end
      if (valid_sr[0])
      begin
         mat_mg <= total_mg;
         mat_eg <= total_eg;
      end
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         board_valid_r <= 1'b0;
         valid_sr      <= '0;
         mat_valid     <= 1'b0;
      end
      else
      begin
         board_valid_r <= board_valid;
         if (clear_eval)
         begin
            valid_sr  <= '0;
            mat_valid <= 1'b0;
         end
         else
         begin
            valid_sr <= {valid_sr[1:0], board_start};
            if (valid_sr[2])
               mat_valid <= 1'b1; // Held until clear_eval.
         end
      end
   end

endmodule

//--- rtl/evaluate_killer.sv
`include "vchess_settings.svh"

module evaluate_killer
(
   input  logic                       clk,
   input  logic                       reset,
   input  logic                       board_valid,
   input  logic [`BOARD_WIDTH-1:0]    board,
   input  logic                       clear_eval,
   input  logic                       white_to_move,
   input  logic [`MAX_DEPTH_LOG2-1:0] killer_ply,
   input  logic [`BOARD_WIDTH-1:0]    killer_board,
   input  logic                       killer_update,
   input  logic                       killer_clear,
   input  vchess_pkg::eval_t          killer_bonus0,
   input  vchess_pkg::eval_t          killer_bonus1,
   output vchess_pkg::eval_t          eval_mg,
   output vchess_pkg::eval_t          eval_eg,
   output logic                       eval_valid
);

   localparam int LATENCY = 4;

   typedef enum logic [1:0] {ST_IDLE, ST_LATENCY, ST_HOLD} state_t;

   state_t                       state;
   logic [1:0]                   count;
   logic                         board_valid_r;
   logic                         killer_update_r;
   logic                         board_start;
   logic                         update_start;
   logic [`MAX_DEPTH_LOG2-1:0]   ply_r;
   logic [`BOARD_WIDTH-1:0]      slot0 [`MAX_DEPTH];
   logic [`BOARD_WIDTH-1:0]      slot1 [`MAX_DEPTH];
   logic [`MAX_DEPTH-1:0]        slot0_valid;
   logic [`MAX_DEPTH-1:0]        slot1_valid;
   logic                         hit0;
   logic                         hit1;
   vchess_pkg::eval_t            bonus;
   vchess_pkg::eval_t            score_r;

   assign board_start  = board_valid && !board_valid_r;
   assign update_start = killer_update && !killer_update_r;

   assign hit0 = slot0_valid[killer_ply] && (board == slot0[killer_ply]);
   assign hit1 = slot1_valid[killer_ply] && (board == slot1[killer_ply]);

   always_comb
   begin
      if (hit0)
         bonus = killer_bonus0; // Newest killer wins.
      else if (hit1)
         bonus = killer_bonus1;
      else
         bonus = '0;
      if (white_to_move)
         bonus = -bonus;
   end

   // Slot 0 holds the most recent killer board.
   always_ff @(posedge clk)
   begin
      ply_r <= killer_ply;
      if (update_start)
      begin
         slot0[ply_r] <= killer_board;
         slot1[ply_r] <= slot0[ply_r];
      end
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         board_valid_r   <= 1'b0;
         killer_update_r <= 1'b0;
         slot0_valid     <= '0;
         slot1_valid     <= '0;
      end
      else
      begin
         board_valid_r   <= board_valid;
         killer_update_r <= killer_update;
         if (killer_clear)
         begin
            slot0_valid <= '0;
            slot1_valid <= '0;
         end
         else if (update_start)
         begin
            slot0_valid[ply_r] <= 1'b1;
            slot1_valid[ply_r] <= slot0_valid[ply_r];
         end
      end
   end

   always_ff @(posedge clk)
   begin
      if (board_start)
         score_r <= bonus;
      eval_mg <= score_r;
      eval_eg <= score_r;
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         state      <= ST_IDLE;
         count      <= '0;
         eval_valid <= 1'b0;
      end
      else
      begin
         case (state)
            ST_IDLE:
            begin
               count      <= '0;
               eval_valid <= 1'b0;
               if (board_start)
                  state <= ST_LATENCY;
            end
            ST_LATENCY:
            begin
               count <= count + 2'd1;
               if (count == 2'(LATENCY - 1))
               begin
                  eval_valid <= 1'b1;
                  state      <= ST_HOLD;
               end
            end
            ST_HOLD:
            begin
               if (clear_eval)
               begin
                  eval_valid <= 1'b0;
                  state      <= ST_IDLE;
               end
            end
            default: state <= ST_IDLE;
         endcase
      end
   end

endmodule

//--- rtl/apb_eval_regs.sv
`include "vchess_settings.svh"

module apb_eval_regs
(
   input  logic                       clk,
   input  logic                       reset,
   input  logic                       psel,
   input  logic                       penable,
   input  logic                       pwrite,
   input  logic [`APB_ADDR_WIDTH-1:0] paddr,
   input  logic [`APB_DATA_WIDTH-1:0] pwdata,
   output logic [`APB_DATA_WIDTH-1:0] prdata,
   output logic                       pready,
   output logic                       pslverr,
   input  logic                       eval_valid,
   output vchess_pkg::eval_t          killer_bonus0,
   output vchess_pkg::eval_t          killer_bonus1,
   output logic                       killer_clear
);

   logic access;
   logic write_access;
   logic mapped;

   assign access       = psel && penable;
   assign write_access = access && pwrite;
   assign pready       = 1'b1; // No wait states.

   always_comb
   begin
      mapped = 1'b1;
      prdata = '0;
      case (paddr)
         `ADDR_BONUS0:  prdata[`EVAL_WIDTH-1:0] = killer_bonus0;
         `ADDR_BONUS1:  prdata[`EVAL_WIDTH-1:0] = killer_bonus1;
         `ADDR_CONTROL: prdata = '0; // Write-only command.
         `ADDR_STATUS:  prdata[0] = eval_valid;
         default:       mapped = 1'b0;
      endcase
   end

   assign pslverr = access && !mapped;

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         killer_bonus0 <= '0;
         killer_bonus1 <= '0;
         killer_clear  <= 1'b0;
      end
      else
      begin
         killer_clear <= 1'b0;
         if (write_access)
         begin
            case (paddr)
               `ADDR_BONUS0:  killer_bonus0 <= pwdata[`EVAL_WIDTH-1:0];
               `ADDR_BONUS1:  killer_bonus1 <= pwdata[`EVAL_WIDTH-1:0];
               `ADDR_CONTROL: killer_clear <= pwdata[0]; // One cycle long.
               default:       killer_clear <= 1'b0;
            endcase
         end
      end
   end

endmodule

//--- rtl/vchess_pkg.sv
`include "vchess_settings.svh"

package vchess_pkg;

   // Kind of piece on a square without its colour.
   typedef enum logic [2:0]
   {
      PIECE_EMPTY  = 3'd0,
      PIECE_PAWN   = 3'd1,
      PIECE_KNIGHT = 3'd2,
      PIECE_BISHOP = 3'd3,
      PIECE_ROOK   = 3'd4,
      PIECE_QUEEN  = 3'd5,
      PIECE_KING   = 3'd6
   } piece_t;

   typedef struct packed
   {
      logic   black; // Set for a black piece.
      piece_t kind;
   } square_t;

   // Positive scores favour white.
   typedef logic signed [`EVAL_WIDTH-1:0] eval_t;

endpackage

//--- include/vchess_settings.svh
`ifndef VCHESS_SETTINGS_SVH
`define VCHESS_SETTINGS_SVH

`define BOARD_WIDTH    256 // 64 squares of 4 bits.
`define MAX_DEPTH      16
`define MAX_DEPTH_LOG2 4
`define EVAL_WIDTH     16

`define APB_ADDR_WIDTH 8
`define APB_DATA_WIDTH 32
`define ADDR_BONUS0    8'h00
`define ADDR_BONUS1    8'h04
`define ADDR_CONTROL   8'h08
`define ADDR_STATUS    8'h0C

`define VAL_MG_PAWN    82
`define VAL_MG_KNIGHT  337
`define VAL_MG_BISHOP  365
`define VAL_MG_ROOK    477
`define VAL_MG_QUEEN   1025
`define VAL_EG_PAWN    94
`define VAL_EG_KNIGHT  281
`define VAL_EG_BISHOP  297
`define VAL_EG_ROOK    512
`define VAL_EG_QUEEN   936

`endif
